// File: list.f
rtl/drive_pkg.sv
rtl/storage_pkg.sv
rtl/head_if.sv
rtl/drive_status.sv
rtl/head_stepper.sv
rtl/track_loader.sv
rtl/track_buffer.sv
rtl/drive_top.sv
testbench/drive_props.sv
testbench/drive_tb.sv

// File: rtl/drive_pkg.sv
package drive_pkg;

	// --------------------
	// head geometry
	// --------------------

	// half-track range of the mechanism
	localparam int TRACK_MIN = 0;
	localparam int TRACK_MAX = 84;

	// where the head parks after a drive reset
	localparam int TRACK_HOME = 36;

	// holds any half-track number up to TRACK_MAX
	localparam int TRACK_W = 7;

	// --------------------
	// timing
	// --------------------

	// ce pulses per stream byte
	localparam int BYTE_CE = 32;
	localparam int BYTE_CE_W = 5;

	// ce-qualified cycles of reset after a drive-mode change
	localparam int RESET_HOLD = 255;
	localparam int RESET_HOLD_W = 8;

	// change window counter, top bit toggles write protect
	localparam int CHANGE_W = 12;

endpackage

// File: rtl/drive_status.sv
module drive_status (
	input  logic        clk,
	input  logic        reset,
	input  logic        ce_i,
	input  logic [1:0]  drv_mode_i,
	input  logic        img_mounted_i,
	input  logic        img_readonly_i,
	input  logic [31:0] img_size_i,
	output logic        drive_reset_o,
	output logic        disk_present_o,
	output logic        wps_n_o
);

	// --------------------
	// image mount
	// --------------------

	logic                          mounted_q;
	logic                          mount_rise;
	logic                          readonly;
	logic [drive_pkg::CHANGE_W-1:0] change_cnt;

	// new image seen on the rising edge only
	assign mount_rise = img_mounted_i & ~mounted_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			mounted_q      <= 1'b0;
			readonly       <= 1'b0;
			disk_present_o <= 1'b0;
			change_cnt     <= '0;
		end else begin
			mounted_q <= img_mounted_i;
			if (mount_rise) begin
				// restart change window
				change_cnt     <= '1;
				readonly       <= img_readonly_i;
				// zero size means empty drive
				disk_present_o <= |img_size_i;
			end else if (ce_i && change_cnt != '0) begin
				change_cnt <= change_cnt - 1'b1;
			end
		end
	end

	// blink during the change window so the controller notices a swap
	assign wps_n_o = ~readonly ^ change_cnt[drive_pkg::CHANGE_W-1];

	// --------------------
	// drive-mode change
	// --------------------

	logic [1:0]                         last_mode;
	logic                               mode_chg;
	logic [drive_pkg::RESET_HOLD_W-1:0] hold_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			last_mode <= drv_mode_i;
			mode_chg  <= 1'b0;
			hold_cnt  <= '0;
		end else if (ce_i) begin
			last_mode <= drv_mode_i;
			if (last_mode != drv_mode_i) begin
				// restart hold on every change
				hold_cnt <= drive_pkg::RESET_HOLD_W'(drive_pkg::RESET_HOLD);
				mode_chg <= 1'b1;
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end else begin
				mode_chg <= 1'b0;
			end
		end
	end

	// drive logic sees either reset source
	assign drive_reset_o = reset | mode_chg;

endmodule

// File: rtl/drive_top.sv
module drive_top (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               ce_i,
	input  logic [1:0]                         drv_mode_i,
	input  logic                               img_mounted_i,
	input  logic                               img_readonly_i,
	input  logic [31:0]                        img_size_i,
	input  logic [1:0]                         stp_i,
	input  logic                               mtr_i,
	input  logic                               act_i,
	input  logic                               mode_i,
	input  logic [7:0]                         din_i,
	output logic [7:0]                         dout_o,
	output logic                               byte_o,
	output logic                               wps_n_o,
	output logic                               tr00_n_o,
	output logic                               led_o,
	output logic [storage_pkg::LBA_W-1:0]      sd_lba_o,
	output logic                               sd_rd_o,
	output logic                               sd_wr_o,
	input  logic                               sd_ack_i,
	input  logic [storage_pkg::BLK_ADDR_W-1:0] sd_buff_addr_i,
	input  logic [7:0]                         sd_buff_dout_i,
	output logic [7:0]                         sd_buff_din_o,
	input  logic                               sd_buff_wr_i
);

	logic                          drive_reset;
	logic                          disk_present;
	logic                          busy;
	logic                          stream_en;
	logic                          track_wr;
	logic [storage_pkg::BLK_W-1:0] blk;

	// stepper to loader requests
	head_if head ();

	// activity lamp also lights during track transfers
	assign led_o = act_i | busy;
	// no rotation without a disk or while the cache is refilled
	assign stream_en = disk_present & ~busy;

	drive_status u_status (
		.clk            (clk),
		.reset          (reset),
		.ce_i           (ce_i),
		.drv_mode_i     (drv_mode_i),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.drive_reset_o  (drive_reset),
		.disk_present_o (disk_present),
		.wps_n_o        (wps_n_o)
	);

	head_stepper u_stepper (
		.clk           (clk),
		.drive_reset_i (drive_reset),
		.stp_i         (stp_i),
		.mtr_i         (mtr_i),
		.act_i         (act_i),
		.track_wr_i    (track_wr),
		.mounted_i     (img_mounted_i),
		.head          (head.stepper),
		.tr00_n_o      (tr00_n_o)
	);

	track_loader u_loader (
		.clk           (clk),
		.drive_reset_i (drive_reset),
		.sd_ack_i      (sd_ack_i),
		.head          (head.loader),
		.sd_lba_o      (sd_lba_o),
		.sd_rd_o       (sd_rd_o),
		.sd_wr_o       (sd_wr_o),
		.blk_o         (blk),
		.busy_o        (busy)
	);

	track_buffer u_buffer (
		.clk            (clk),
		.drive_reset_i  (drive_reset),
		.ce_i           (ce_i),
		.stream_en_i    (stream_en),
		.mode_i         (mode_i),
		.din_i          (din_i),
		.sd_ack_i       (sd_ack_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.sd_buff_addr_i (sd_buff_addr_i),
		.sd_buff_dout_i (sd_buff_dout_i),
		.blk_i          (blk),
		.dout_o         (dout_o),
		.byte_o         (byte_o),
		.track_wr_o     (track_wr),
		.sd_buff_din_o  (sd_buff_din_o)
	);

endmodule

// File: rtl/head_if.sv
interface head_if;

	// current half-track under the head
	logic [drive_pkg::TRACK_W-1:0] track_num;

	// half-track to be written back
	logic [drive_pkg::TRACK_W-1:0] save_track;

	// track requests, valid/ready pairs
	logic                          load_valid;
	logic                          load_ready;
	logic                          save_valid;
	logic                          save_ready;

	// head side raises requests
	modport stepper (
		output track_num, save_track, load_valid, save_valid,
		input  load_ready, save_ready
	);

	// storage side accepts them
	modport loader (
		input  track_num, save_track, load_valid, save_valid,
		output load_ready, save_ready
	);

endinterface

// File: rtl/head_stepper.sv
module head_stepper (
	input  logic       clk,
	input  logic       drive_reset_i,
	input  logic [1:0] stp_i,
	input  logic       mtr_i,
	input  logic       act_i,
	input  logic       track_wr_i,
	input  logic       mounted_i,
	head_if.stepper    head,
	output logic       tr00_n_o
);

	logic [1:0] stp_q;
	// phase difference, 1 is inward and 3 is outward
	logic [1:0] move;
	logic       step;
	logic       step_q;
	logic       save_pend;
	logic       modified;
	logic       act_q;
	logic       act_fall;
	logic       rst_load;

	// odd difference is a single step, only with motor on
	assign step     = mtr_i & move[0];
	assign act_fall = act_q & ~act_i;

	always_ff @(posedge clk) begin
		if (drive_reset_i) begin
			stp_q           <= stp_i;
			move            <= 2'd0;
			act_q           <= act_i;
			step_q          <= 1'b0;
			save_pend       <= 1'b0;
			modified        <= 1'b0;
			rst_load        <= 1'b1;
			head.track_num  <= drive_pkg::TRACK_W'(drive_pkg::TRACK_HOME);
			head.load_valid <= 1'b0;
			head.save_valid <= 1'b0;
		end else begin
			stp_q     <= stp_i;
			move      <= stp_i - stp_q;
			act_q     <= act_i;
			step_q    <= step;
			save_pend <= 1'b0;
			rst_load  <= 1'b0;

			// --------------------
			// handshake retire
			// --------------------
			if (head.load_valid && head.load_ready)
				head.load_valid <= 1'b0;
			if (head.save_valid && head.save_ready)
				head.save_valid <= 1'b0;

			// any stream write dirties the cache
			if (track_wr_i)
				modified <= 1'b1;

			if (step) begin
				// clamp at both ends of the range
				if (!move[1] && head.track_num < drive_pkg::TRACK_MAX)
					head.track_num <= head.track_num + 1'b1;
				if (move[1] && head.track_num > drive_pkg::TRACK_MIN)
					head.track_num <= head.track_num - 1'b1;
				if (modified) begin
					save_pend <= 1'b1;
					// pending save keeps its own track
					if (!head.save_valid)
						head.save_track <= head.track_num;
				end
				modified <= 1'b0;
			end else if (act_fall && modified) begin
				// activity stopped, flush the dirty track
				head.save_valid <= 1'b1;
				if (!head.save_valid)
					head.save_track <= head.track_num;
				modified <= 1'b0;
			end

			// requests follow the track update by one cycle
			if (step_q || rst_load)
				head.load_valid <= 1'b1;
			if (save_pend)
				head.save_valid <= 1'b1;

			// fresh image, nothing to write back
			if (mounted_i)
				modified <= 1'b0;
		end
	end

	assign tr00_n_o = (head.track_num != drive_pkg::TRACK_W'(drive_pkg::TRACK_MIN));

endmodule

// File: rtl/storage_pkg.sv
package storage_pkg;

	// --------------------
	// block geometry
	// --------------------

	// one storage block
	localparam int BLK_BYTES = 256;
	localparam int BLK_ADDR_W = 8;

	// a cached track is a run of consecutive blocks
	localparam int BLKS_PER_TRACK = 4;
	localparam int BLK_W = 2;
	localparam int TRACK_BYTES = BLK_BYTES * BLKS_PER_TRACK;
	localparam int TRACK_ADDR_W = 10;

	// --------------------
	// request port
	// --------------------

	// logical block address
	localparam int LBA_W = 32;

endpackage

// File: rtl/track_buffer.sv
module track_buffer (
	input  logic                                clk,
	input  logic                                drive_reset_i,
	input  logic                                ce_i,
	input  logic                                stream_en_i,
	input  logic                                mode_i,
	input  logic [7:0]                          din_i,
	input  logic                                sd_ack_i,
	input  logic                                sd_buff_wr_i,
	input  logic [storage_pkg::BLK_ADDR_W-1:0]  sd_buff_addr_i,
	input  logic [7:0]                          sd_buff_dout_i,
	input  logic [storage_pkg::BLK_W-1:0]       blk_i,
	output logic [7:0]                          dout_o,
	output logic                                byte_o,
	output logic                                track_wr_o,
	output logic [7:0]                          sd_buff_din_o
);

	// one whole track
	logic [7:0] ram [storage_pkg::TRACK_BYTES];

	logic [storage_pkg::TRACK_ADDR_W-1:0] sd_addr;
	logic [storage_pkg::TRACK_ADDR_W-1:0] ptr;
	logic [drive_pkg::BYTE_CE_W-1:0]      prescale;
	logic                                 byte_time;
	logic                                 stream_we;
	logic                                 sd_we;

	// --------------------
	// address and strobes
	// --------------------

	// block selects the quarter, storage offset the byte
	assign sd_addr = {blk_i, sd_buff_addr_i};
	assign sd_we   = sd_ack_i & sd_buff_wr_i;

	// last ce pulse of a byte time
	assign byte_time = stream_en_i & ce_i
	                   & (prescale == drive_pkg::BYTE_CE_W'(drive_pkg::BYTE_CE - 1));
	assign stream_we = byte_time & mode_i;

	// --------------------
	// track ram
	// --------------------

	// ports never write together, stream is stopped while busy
	always_ff @(posedge clk) begin
		if (sd_we)
			ram[sd_addr] <= sd_buff_dout_i;
		else if (stream_we)
			ram[ptr] <= din_i;
	end

	// storage readback, one cycle late
	always_ff @(posedge clk) begin
		sd_buff_din_o <= ram[sd_addr];
	end

	// byte under the head, held between byte times
	always_ff @(posedge clk) begin
		if (byte_time)
			dout_o <= ram[ptr];
	end

	// --------------------
	// rotation
	// --------------------

	always_ff @(posedge clk) begin
		if (drive_reset_i) begin
			prescale   <= '0;
			ptr        <= '0;
			byte_o     <= 1'b0;
			track_wr_o <= 1'b0;
		end else begin
			byte_o     <= byte_time;
			track_wr_o <= stream_we;
			// disk stands still while disabled
			if (stream_en_i && ce_i)
				prescale <= byte_time ? '0 : prescale + 1'b1;
			if (byte_time) begin
				if (ptr == storage_pkg::TRACK_ADDR_W'(storage_pkg::TRACK_BYTES - 1))
					ptr <= '0;
				else
					ptr <= ptr + 1'b1;
			end
		end
	end

endmodule

// File: rtl/track_loader.sv
module track_loader (
	input  logic                            clk,
	input  logic                            drive_reset_i,
	input  logic                            sd_ack_i,
	head_if.loader                          head,
	output logic [storage_pkg::LBA_W-1:0]   sd_lba_o,
	output logic                            sd_rd_o,
	output logic                            sd_wr_o,
	output logic [storage_pkg::BLK_W-1:0]   blk_o,
	output logic                            busy_o
);

	// --------------------
	// sequencer state
	// --------------------

	// idle when not busy
	logic                          busy_q;
	// request phase, waiting for ack to rise
	logic                          req_q;
	// block transfer direction, high for a save
	logic                          wr_mode;
	// block within the track
	logic [storage_pkg::BLK_W-1:0] blk;
	logic [storage_pkg::LBA_W-1:0] lba_q;
	logic                          last_blk;

	assign last_blk = (blk == storage_pkg::BLK_W'(storage_pkg::BLKS_PER_TRACK - 1));

	// saves win over loads
	assign head.save_ready = ~busy_q;
	assign head.load_ready = ~busy_q & ~head.save_valid;

	always_ff @(posedge clk) begin
		if (drive_reset_i) begin
			busy_q  <= 1'b0;
			req_q   <= 1'b0;
			wr_mode <= 1'b0;
			blk     <= '0;
		end else if (!busy_q) begin
			if (head.save_valid) begin
				// write back old track
				busy_q  <= 1'b1;
				req_q   <= 1'b1;
				wr_mode <= 1'b1;
				blk     <= '0;
				lba_q   <= storage_pkg::LBA_W'(head.save_track)
				           * storage_pkg::BLKS_PER_TRACK;
			end else if (head.load_valid) begin
				// fetch current track
				busy_q  <= 1'b1;
				req_q   <= 1'b1;
				wr_mode <= 1'b0;
				blk     <= '0;
				lba_q   <= storage_pkg::LBA_W'(head.track_num)
				           * storage_pkg::BLKS_PER_TRACK;
			end
		end else if (req_q) begin
			// storage took the request
			if (sd_ack_i)
				req_q <= 1'b0;
		end else if (!sd_ack_i) begin
			// block done on falling ack
			if (last_blk) begin
				busy_q <= 1'b0;
			end else begin
				blk   <= blk + 1'b1;
				lba_q <= lba_q + 1'b1;
				req_q <= 1'b1;
			end
		end
	end

	// --------------------
	// storage port
	// --------------------

	assign sd_lba_o = lba_q;
	assign sd_rd_o  = req_q & ~wr_mode;
	assign sd_wr_o  = req_q & wr_mode;
	assign blk_o    = blk;
	assign busy_o   = busy_q;

endmodule

// File: testbench/drive_props.sv
module drive_props (
	input logic                            clk,
	input logic                            reset,
	input logic                            rd,
	input logic                            wr,
	input logic                            ack,
	input logic [storage_pkg::LBA_W-1:0]   lba,
	input logic                            load_valid,
	input logic                            load_ready,
	input logic                            save_valid,
	input logic                            save_ready,
	input logic [drive_pkg::TRACK_W-1:0]   save_track,
	input logic [drive_pkg::TRACK_W-1:0]   track_num
);

	// failed assertions, read back at the end of the run
	int fails = 0;

	// --------------------
	// storage port
	// --------------------

	// request keeps its direction and block until the ack
	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		(rd || wr) && !ack |=> $stable(rd) && $stable(wr) && $stable(lba))
		else begin
			$error("storage request changed before ack");
			fails++;
		end

	// --------------------
	// head requests
	// --------------------

	// load holds until taken
	a_load_hold: assert property (@(posedge clk) disable iff (reset)
		load_valid && !load_ready |=> load_valid)
		else begin
			$error("load request dropped before ready");
			fails++;
		end

	// save holds with a stable track
	a_save_hold: assert property (@(posedge clk) disable iff (reset)
		save_valid && !save_ready |=> save_valid && $stable(save_track))
		else begin
			$error("save request dropped or changed before ready");
			fails++;
		end

	// head never leaves the half-track range
	a_track_range: assert property (@(posedge clk) disable iff (reset)
		track_num <= drive_pkg::TRACK_MAX)
		else begin
			$error("half-track out of range");
			fails++;
		end

endmodule

bind drive_top drive_props u_props (
	.clk        (clk),
	.reset      (drive_reset),
	.rd         (sd_rd_o),
	.wr         (sd_wr_o),
	.ack        (sd_ack_i),
	.lba        (sd_lba_o),
	.load_valid (head.load_valid),
	.load_ready (head.load_ready),
	.save_valid (head.save_valid),
	.save_ready (head.save_ready),
	.save_track (head.save_track),
	.track_num  (head.track_num)
);

// File: testbench/drive_tb.sv
module drive_tb;

	localparam int N_ENTRIES = 13;
	localparam int ENTRY_CYCLES = 80000;
	// table operations
	localparam int OP_WAIT = 0, OP_MOUNT_RO = 1, OP_MOUNT_RW = 2, OP_STREAM = 3;
	localparam int OP_WRITE = 4, OP_IN = 5, OP_OUT = 6, OP_MODE = 7, OP_EMPTY = 8;

	logic        clk, reset, ce_i, img_mounted_i, img_readonly_i, mtr_i, act_i, mode_i;
	logic [1:0]  drv_mode_i, stp_i;
	logic [31:0] img_size_i;
	logic [7:0]  din_i, dout_o, sd_buff_addr_i, sd_buff_dout_i, sd_buff_din_o;
	logic        byte_o, wps_n_o, tr00_n_o, led_o, sd_rd_o, sd_wr_o, sd_ack_i, sd_buff_wr_i;
	logic [31:0] sd_lba_o;

	int          errors = 0;
	int          checks = 0;
	int          last_rd_lba = -1;
	int          last_wr_lba = -1;
	int          ptr = 0;
	bit          ptr_clear = 0;
	logic [7:0]  shadow [1024];
	bit          shadow_ok [1024];
	logic [7:0]  cap [int];
	int          wr_addr [$];
	logic [7:0]  wr_data [$];
	logic        wr_en_q;
	logic [7:0]  wr_d_q;
	// stimulus table of operation, repeat count and half-track expected afterwards
	int          tab_op [N_ENTRIES] = '{OP_WAIT, OP_MOUNT_RO, OP_MOUNT_RW, OP_STREAM,
		OP_WRITE, OP_IN, OP_IN, OP_IN, OP_OUT, OP_OUT, OP_MODE, OP_STREAM, OP_EMPTY};
	int          tab_cnt [N_ENTRIES] = '{0, 0, 0, 40, 6, 1, 47, 2, 84, 1, 0, 20, 0};
	int          tab_trk [N_ENTRIES] = '{36, 36, 36, 36, 36, 37, 84, 84, 0, 0, 36, 36, 36};

	drive_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// stored byte for a block offset with the block counted within its track
	function automatic logic [7:0] pattern(int lba, int off);
		return 8'((off + 16 * (lba % 4) + 7 * lba) % 256);
	endfunction

	task automatic check_eq(string name, int got, int exp);
		checks++;
		assert (got == exp) else begin
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// --------------------
	// storage model
	// --------------------

	task automatic serve_block();
		int lba;
		bit is_wr;
		lba = sd_lba_o;
		is_wr = sd_wr_o;
		// lamp lights for every track transfer
		check_eq("led_o", led_o, 1);
		repeat ($urandom % 16) @(negedge clk);
		sd_ack_i = 1'b1;
		if (is_wr) begin
			sd_buff_addr_i = 8'd0;
			for (int off = 0; off < 256; off++) begin
				@(negedge clk);
				// readback lags the address by one cycle
				cap[lba * 256 + off] = sd_buff_din_o;
				sd_buff_addr_i = 8'(off + 1);
			end
			if (lba % 4 == 0)
				last_wr_lba = lba;
		end else begin
			for (int off = 0; off < 256; off++) begin
				sd_buff_addr_i = 8'(off);
				sd_buff_wr_i = 1'b1;
				sd_buff_dout_i = pattern(lba, off);
				shadow[(lba % 4) * 256 + off] = pattern(lba, off);
				shadow_ok[(lba % 4) * 256 + off] = 1'b1;
				@(negedge clk);
			end
			sd_buff_wr_i = 1'b0;
			if (lba % 4 == 0)
				last_rd_lba = lba;
		end
		sd_ack_i = 1'b0;
	endtask

	initial begin
		forever begin
			@(negedge clk);
			if (sd_rd_o || sd_wr_o)
				serve_block();
		end
	end

	// --------------------
	// stream monitor
	// --------------------

	// stream write enable and data as the DUT saw them
	always @(posedge clk) begin
		wr_en_q <= mode_i;
		wr_d_q <= din_i;
	end

	always @(negedge clk) begin
		if (ptr_clear) begin
			ptr = 0;
			ptr_clear = 0;
		end else if (byte_o) begin
			if (shadow_ok[ptr])
				check_eq("dout_o", dout_o, shadow[ptr]);
			if (wr_en_q) begin
				shadow[ptr] = wr_d_q;
				wr_addr.push_back(ptr);
				wr_data.push_back(wr_d_q);
			end
			ptr = (ptr + 1) % 1024;
		end
	end

	// --------------------
	// operations
	// --------------------

	// track transfers finish once led and requests stay quiet
	task automatic wait_xfer();
		int quiet;
		bit seen;
		quiet = 0;
		seen = 0;
		while (!(seen && quiet >= 4)) begin
			@(negedge clk);
			if (led_o || sd_rd_o || sd_wr_o) begin
				seen = 1;
				quiet = 0;
			end else begin
				quiet++;
			end
		end
	endtask

	task automatic wait_bytes(int n);
		for (int i = 0; i < n; i++) begin
			do @(negedge clk); while (!byte_o);
			din_i = din_i + 8'd3;
		end
	endtask

	task automatic mount(bit ro, int size);
		img_readonly_i = ro;
		img_size_i = size;
		img_mounted_i = 1'b1;
		@(negedge clk);
		img_mounted_i = 1'b0;
		repeat (4) @(negedge clk);
		// blink phase shows the inverse of the settled level
		check_eq("wps_n_o", wps_n_o, ro);
		repeat (4200) @(negedge clk);
		check_eq("wps_n_o", wps_n_o, !ro);
	endtask

	task automatic step(int dir, int old_trk);
		stp_i = stp_i + 2'(dir);
		wait_xfer();
		// dirty track goes back before the new read
		if (wr_addr.size() > 0) begin
			check_eq("sd_lba_o (save)", last_wr_lba, old_trk * 4);
			foreach (wr_addr[i])
				check_eq("captured byte", cap[old_trk * 1024 + wr_addr[i]], wr_data[i]);
			wr_addr.delete();
			wr_data.delete();
		end
	endtask

	task automatic run_entry(int op, int cnt, int trk, ref int cur);
		int seen;
		case (op)
			OP_WAIT: wait_xfer();
			OP_MOUNT_RO: mount(1'b1, 32'd174848);
			OP_MOUNT_RW: mount(1'b0, 32'd174848);
			OP_STREAM: wait_bytes(cnt);
			OP_WRITE: begin
				mode_i = 1'b1;
				wait_bytes(cnt);
				mode_i = 1'b0;
			end
			OP_IN, OP_OUT: begin
				for (int i = 0; i < cnt; i++) begin
					step(op == OP_IN ? 1 : -1, cur);
					// head clamps at either end of the half-track range
					if (op == OP_IN && cur < drive_pkg::TRACK_MAX)
						cur++;
					else if (op == OP_OUT && cur > drive_pkg::TRACK_MIN)
						cur--;
					check_eq("sd_lba_o (load)", last_rd_lba, cur * 4);
				end
			end
			OP_MODE: begin
				drv_mode_i = drv_mode_i ^ 2'd1;
				@(posedge clk);
				@(posedge clk);
				ptr_clear = 1;
				wait_xfer();
			end
			OP_EMPTY: begin
				img_size_i = 32'd0;
				img_mounted_i = 1'b1;
				@(negedge clk);
				img_mounted_i = 1'b0;
				seen = 0;
				repeat (300) begin
					@(negedge clk);
					seen += byte_o;
				end
				check_eq("byte_o pulses", seen, 0);
			end
			default: ;
		endcase
		cur = trk;
		check_eq("sd_lba_o (load)", last_rd_lba, trk * 4);
		check_eq("tr00_n_o", tr00_n_o, trk != 0);
	endtask

	initial begin
		#(N_ENTRIES * ENTRY_CYCLES * 10);
		$display("watchdog expired before the stimulus table completed");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		int cur;
		int total;
		void'($urandom(32'hf71b8f48));
		reset = 1'b1;
		ce_i = 1'b1;
		drv_mode_i = 2'd0;
		img_mounted_i = 1'b0;
		img_readonly_i = 1'b0;
		img_size_i = 32'd0;
		stp_i = 2'd0;
		mtr_i = 1'b1;
		act_i = 1'b0;
		mode_i = 1'b0;
		din_i = 8'h5a;
		sd_ack_i = 1'b0;
		sd_buff_addr_i = 8'd0;
		sd_buff_dout_i = 8'd0;
		sd_buff_wr_i = 1'b0;
		cur = 36;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		for (int e = 0; e < N_ENTRIES; e++)
			run_entry(tab_op[e], tab_cnt[e], tab_trk[e], cur);
		// bound assertion failures count as errors too
		total = errors + uut.u_props.fails;
		$display("checks: %0d, errors: %0d", checks, total);
		if (total == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
